//--- compile.f
verilog/dsi3_pkg.sv
verilog/dsi3_filter.sv
verilog/dsi3_chip_sampler.sv
verilog/dsi3_symbol_decoder.sv
verilog/dsi3_rx_top.sv
tb/dsi3_rx_tb.sv

//--- Makefile
# Verilator build and run of the DSI3 receive front end

VERILATOR   ?= verilator
TOP         ?= dsi3_rx_tb
BUILD_DIR   ?= obj_dir
FILE_LIST   ?= compile.f
VFLAGS      ?= --binary --timing --assert
PASS_STRING ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILE_LIST VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_STRING)'

clean:
	rm -rf $(BUILD_DIR)

//--- tb/dsi3_rx_tb.sv
`timescale 1ns/1ps

module dsi3_rx_tb;
	import dsi3_pkg::*;

	localparam int unsigned FILTER_LONG    = 24;
	localparam int unsigned FILTER_SHORT   = 16;
	localparam int unsigned CHIP_CYCLES    = 64;
	localparam int unsigned PACKET_SYMBOLS = 4;
	localparam int unsigned CHIPS          = 3 * PACKET_SYMBOLS;
	localparam int unsigned SETTLE         = 2 * FILTER_LONG + 8;
	localparam int unsigned GAP            = 2 * FILTER_LONG + 16;
	localparam int unsigned LATENCY        = FILTER_LONG + 3 + (CHIPS - 1) * CHIP_CYCLES
		+ CHIP_CYCLES / 2 + 1;
	localparam int unsigned PACKETS        = 8;
	localparam int unsigned FILTER_CYCLES  = 12 * (SETTLE + FILTER_LONG + 4)
		+ 4 * (SETTLE + FILTER_LONG + SETTLE) + 8 * (SETTLE + 500 + 2);
	localparam int unsigned WATCHDOG_CYCLES = 2 * (FILTER_CYCLES
		+ PACKETS * (CHIPS * CHIP_CYCLES + GAP) + 20);

	typedef struct packed {
		logic [4*PACKET_SYMBOLS_MAX-1:0] data;
		logic                            error;
	} expect_s;

	logic          clk;
	logic          rst_n;
	logic [1:0]    rx;
	logic          short_filter_time;
	dsi3_chip_e    chip_filtered;
	dsi3_packet_s  packet;

	int            errors;
	int            tests_failed;
	int            errors_at_start;
	logic          check_on;
	expect_s       expected [$];
	expect_s       got_exp;
	dsi3_chip_e    chips [CHIPS];
	int unsigned   first_ok [$];

	dsi3_rx_top #(
		.FILTER_LONG    (FILTER_LONG),
		.FILTER_SHORT   (FILTER_SHORT),
		.CHIP_CYCLES    (CHIP_CYCLES),
		.PACKET_SYMBOLS (PACKET_SYMBOLS)
	) dut_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.rx                (rx),
		.short_filter_time (short_filter_time),
		.chip_filtered     (chip_filtered),
		.packet            (packet)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic value_error(input string what, input int got, input int exp);
		errors++;
		$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
	endtask

	// ======================================================================
	// Filter reference model
	// ======================================================================

	logic [1:0]  m_meta;
	logic [1:0]  m_sync;
	int unsigned m_cnt [2];
	logic [1:0]  m_level;
	dsi3_chip_e  model_chip;

	always @(posedge clk) begin : filter_model
		int unsigned lim;
		int unsigned c;
		lim = short_filter_time ? FILTER_SHORT : FILTER_LONG;
		if (!rst_n) begin
			m_meta <= 2'b00;
			m_sync <= 2'b00;
			m_cnt[0] <= 0;
			m_cnt[1] <= 0;
			m_level <= 2'b00;
			model_chip <= C0;
		end else begin
			m_meta <= rx;
			m_sync <= m_meta;
			for (int i = 0; i < 2; i++) begin
				c = (m_cnt[i] > lim) ? lim : m_cnt[i];
				if (m_sync[i]) c = (c < lim) ? c + 1 : c;
				else c = (c > 0) ? c - 1 : c;
				m_cnt[i] <= c;
				if (c == lim) m_level[i] <= 1'b1;
				else if (c == 0) m_level[i] <= 1'b0;
			end
			// Upper comparator alone counts as C1
			case (m_level)
				2'b00: model_chip <= C0;
				2'b11: model_chip <= C2;
				default: model_chip <= C1;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) chip_filtered == model_chip)
		else value_error("chip_filtered against model", int'(chip_filtered),
			int'(model_chip));

	// Packet monitor that pops one expected entry per valid pulse
	always @(negedge clk) begin
		if (rst_n && check_on && packet.valid) begin
			if (expected.size() == 0) begin
				errors++;
				$display("A packet arrived at %0t ns while none was expected", $time);
			end else begin
				got_exp = expected.pop_front();
				assert (packet.error == got_exp.error)
					else value_error("packet.error", int'(packet.error), int'(got_exp.error));
				if (!got_exp.error) begin
					assert (packet.data == got_exp.data)
						else value_error("packet.data", packet.data, got_exp.data);
				end
			end
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic hold_level(input dsi3_chip_e level, input logic short_sel, input int n);
		@(posedge clk);
		rx <= level;
		short_filter_time <= short_sel;
		repeat (n) @(posedge clk);
	endtask

	task automatic check_step(input dsi3_chip_e from, input dsi3_chip_e to,
			input logic short_sel);
		int unsigned lim;
		lim = short_sel ? FILTER_SHORT : FILTER_LONG;
		hold_level(from, short_sel, SETTLE);
		rx <= to;
		repeat (lim + 2) @(posedge clk);
		@(negedge clk);
		assert (chip_filtered == from)
			else value_error("chip_filtered early", int'(chip_filtered), int'(from));
		@(negedge clk);
		assert (chip_filtered == to)
			else value_error("chip_filtered on time", int'(chip_filtered), int'(to));
	endtask

	task automatic reject_noise(input dsi3_chip_e level, input dsi3_chip_e other,
			input logic short_sel);
		int unsigned lim;
		lim = short_sel ? FILTER_SHORT : FILTER_LONG;
		hold_level(level, short_sel, SETTLE);
		for (int n = 0; n < lim - 1 + SETTLE; n++) begin
			@(posedge clk);
			rx <= (n < lim - 1) ? other : level;
			@(negedge clk);
			assert (chip_filtered == level)
				else value_error("chip_filtered under noise", int'(chip_filtered),
					int'(level));
		end
	endtask

	task automatic toggle_duty(input int high);
		dsi3_chip_e major;
		major = (high > 5) ? C2 : C0;
		hold_level(C0, 1'b0, SETTLE);
		for (int p = 0; p < 50; p++) begin
			for (int c = 0; c < 10; c++) begin
				@(posedge clk);
				rx <= (c < high) ? C2 : C0;
			end
		end
		@(negedge clk);
		assert (chip_filtered == major) else value_error("chip_filtered after toggling",
			int'(chip_filtered), int'(major));
	endtask

	// Bad triplet index selects one symbol slot to replace with C1 C1 C1
	task automatic send_packet(input int bad_triplet);
		expect_s exp;
		int unsigned sym;
		exp = '0;
		for (int s = 0; s < PACKET_SYMBOLS; s++) begin
			sym = (s == 0) ? first_ok[$urandom % first_ok.size()] : $urandom % 16;
			exp.data[4*PACKET_SYMBOLS_MAX-1-4*s -: 4] = 4'(sym);
			chips[3*s]     = symbol_chip_table[sym].first;
			chips[3*s + 1] = symbol_chip_table[sym].second;
			chips[3*s + 2] = symbol_chip_table[sym].third;
			if (s == bad_triplet) begin
				chips[3*s]     = C1;
				chips[3*s + 1] = C1;
				chips[3*s + 2] = C1;
			end
		end
		exp.error = (bad_triplet >= 0);
		expected.push_back(exp);
		for (int n = 0; n < CHIPS * CHIP_CYCLES; n++) begin
			@(posedge clk);
			rx <= chips[n / CHIP_CYCLES];
			@(negedge clk);
			if (n == LATENCY - 1) begin
				assert (!packet.valid)
					else value_error("packet.valid early", int'(packet.valid), 0);
			end
			if (n == LATENCY) begin
				assert (packet.valid)
					else value_error("packet.valid on time", int'(packet.valid), 1);
			end
		end
		hold_level(C0, 1'b0, GAP);
		if (expected.size() != 0) begin
			errors++;
			expected.delete();
			$display("A packet was sent but no valid pulse came for it");
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (errors != errors_at_start) tests_failed++;
		$display("test %0d %s: %s", num, name, (errors == errors_at_start) ? "ok" : "failed");
		errors_at_start = errors;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		rst_n = 1'b0;
		rx = 2'b00;
		short_filter_time = 1'b0;
		check_on = 1'b0;
		errors = 0;
		tests_failed = 0;
		errors_at_start = 0;
		void'($urandom(32'h1a93));
		for (int i = 0; i < 16; i++) begin
			if (symbol_chip_table[i].first != C0) first_ok.push_back(i);
		end
		apply_reset();

		for (int f = 0; f < 2; f++) begin
			for (int a = 0; a < 3; a++) begin
				for (int b = 0; b < 3; b++) begin
					if (a != b) check_step(dsi3_chip_e'(a == 2 ? 3 : a),
						dsi3_chip_e'(b == 2 ? 3 : b), f[0]);
				end
			end
		end
		finish_test(1, "step response");

		for (int f = 0; f < 2; f++) begin
			reject_noise(C0, C2, f[0]);
			reject_noise(C2, C0, f[0]);
		end
		finish_test(2, "noise rejection");

		for (int d = 1; d <= 9; d++) begin
			if (d != 5) toggle_duty(d);
		end
		finish_test(3, "duty-cycle toggling");

		// Sampler may be mid packet from the filter tests
		hold_level(C0, 1'b0, 2);
		apply_reset();
		check_on = 1'b1;
		hold_level(C0, 1'b0, SETTLE);
		for (int p = 0; p < 6; p++) send_packet(-1);
		finish_test(4, "packet decoding");

		send_packet(1);
		send_packet(-1);
		finish_test(5, "invalid triplet");

		$display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("The run took too long and was stopped by the watchdog");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verilog/dsi3_rx_top.sv
`timescale 1ns/1ps

module dsi3_rx_top #(
	parameter int unsigned FILTER_LONG    = 24,
	parameter int unsigned FILTER_SHORT   = 16,
	parameter int unsigned CHIP_CYCLES    = 64,
	parameter int unsigned PACKET_SYMBOLS = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [1:0]             rx,
	input  logic                   short_filter_time,
	output dsi3_pkg::dsi3_chip_e   chip_filtered,
	output dsi3_pkg::dsi3_packet_s packet
);

	dsi3_pkg::chip_sample_s chip_sample;

	// Comparator code to a clean chip level
	dsi3_filter #(
		.FILTER_LONG  (FILTER_LONG),
		.FILTER_SHORT (FILTER_SHORT)
	) u_filter (
		.clk               (clk),
		.rst_n             (rst_n),
		.rx                (rx),
		.short_filter_time (short_filter_time),
		.chip_filtered     (chip_filtered)
	);

	dsi3_chip_sampler #(
		.CHIP_CYCLES    (CHIP_CYCLES),
		.PACKET_SYMBOLS (PACKET_SYMBOLS)
	) u_sampler (
		.clk           (clk),
		.rst_n         (rst_n),
		.chip_filtered (chip_filtered),
		.chip_sample   (chip_sample)
	);

	dsi3_symbol_decoder #(
		.PACKET_SYMBOLS (PACKET_SYMBOLS)
	) u_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.chip_sample (chip_sample),
		.packet      (packet)
	);

endmodule

//--- verilog/dsi3_symbol_decoder.sv
`timescale 1ns/1ps

module dsi3_symbol_decoder #(
	parameter int unsigned PACKET_SYMBOLS = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dsi3_pkg::chip_sample_s chip_sample,
	output dsi3_pkg::dsi3_packet_s packet
);
	import dsi3_pkg::*;

	localparam int unsigned DATA_W = 4 * PACKET_SYMBOLS_MAX;
	localparam int unsigned PAD    = 4 * (PACKET_SYMBOLS_MAX - PACKET_SYMBOLS);
	localparam int unsigned SYM_W  = $clog2(PACKET_SYMBOLS + 1);

	localparam logic [SYM_W-1:0] SYM_LAST = SYM_W'(PACKET_SYMBOLS - 1);

	logic [1:0]        chip_idx;
	logic [SYM_W-1:0]  sym_cnt;
	logic              err_acc;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] acc_next;
	dsi3_chip_e        chip_a;
	dsi3_chip_e        chip_b;
	chip_triplet_s     triplet;
	symbol_lookup_s    lookup;
	logic              triplet_done;
	logic              last_triplet;
	logic              valid_q;
	logic [DATA_W-1:0] data_q;
	logic              error_q;

	// ======================================================================
	// Triplet decode
	// ======================================================================

	always_comb begin
		triplet      = '{first: chip_a, second: chip_b, third: chip_sample.chip};
		lookup       = chips_to_symbol(triplet);
		acc_next     = {acc[DATA_W-5:0], lookup.symbol};
		triplet_done = chip_sample.strobe && (chip_idx == 2'd2);
		last_triplet = triplet_done && (sym_cnt == SYM_LAST);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chip_idx <= 2'd0;
			sym_cnt  <= '0;
			err_acc  <= 1'b0;
			acc      <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (triplet_done) begin
				chip_idx <= 2'd0;
				if (last_triplet) begin
					sym_cnt <= '0;
					err_acc <= 1'b0;
					acc     <= '0;
					valid_q <= 1'b1;
				end else begin
					sym_cnt <= sym_cnt + 1'b1;
					err_acc <= err_acc | ~lookup.found;
					acc     <= acc_next;
				end
			end else if (chip_sample.strobe) begin
				chip_idx <= chip_idx + 1'b1;
			end
		end
	end

	// ======================================================================
	// Chip holding and packet word
	// ======================================================================

	always_ff @(posedge clk) begin
		if (chip_sample.strobe && chip_idx == 2'd0) begin
			chip_a <= chip_sample.chip;
		end
		if (chip_sample.strobe && chip_idx == 2'd1) begin
			chip_b <= chip_sample.chip;
		end
		// Left align so the first symbol ends up in the top nibble
		if (last_triplet) begin
			data_q  <= acc_next << PAD;
			error_q <= err_acc | ~lookup.found;
		end
	end

	assign packet = '{valid: valid_q, data: data_q, error: error_q};

endmodule

//--- verilog/dsi3_chip_sampler.sv
`timescale 1ns/1ps

module dsi3_chip_sampler #(
	parameter int unsigned CHIP_CYCLES    = 64,
	parameter int unsigned PACKET_SYMBOLS = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dsi3_pkg::dsi3_chip_e   chip_filtered,
	output dsi3_pkg::chip_sample_s chip_sample
);
	import dsi3_pkg::*;

	localparam int unsigned PHASE_W = $clog2(CHIP_CYCLES);
	localparam int unsigned CHIPS   = 3 * PACKET_SYMBOLS;
	localparam int unsigned CHIP_W  = $clog2(CHIPS);

	// Loaded on start so that the first strobe lands half a chip later
	localparam logic [PHASE_W-1:0] PHASE_START = PHASE_W'(CHIP_CYCLES / 2 + 1);
	localparam logic [PHASE_W-1:0] PHASE_LAST  = PHASE_W'(CHIP_CYCLES - 1);
	localparam logic [CHIP_W-1:0]  CHIP_LAST   = CHIP_W'(CHIPS - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RECEIVE,
		S_WAIT_IDLE
	} state_e;

	state_e            state;
	logic [PHASE_W-1:0] phase;
	logic [CHIP_W-1:0]  chip_cnt;
	logic              strobe;
	logic              sample_now;
	dsi3_chip_e        chip_q;

	assign sample_now = (state == S_RECEIVE) && (phase == PHASE_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			phase    <= '0;
			chip_cnt <= '0;
			strobe   <= 1'b0;
		end else begin
			strobe <= 1'b0;
			case (state)
				S_IDLE: begin
					// Any level above C0 is the first chip of a packet
					if (chip_filtered != C0) begin
						state    <= S_RECEIVE;
						phase    <= PHASE_START;
						chip_cnt <= '0;
					end
				end
				S_RECEIVE: begin
					if (sample_now) begin
						phase    <= '0;
						strobe   <= 1'b1;
						chip_cnt <= chip_cnt + 1'b1;
						if (chip_cnt == CHIP_LAST) begin
							state <= S_WAIT_IDLE;
						end
					end else begin
						phase <= phase + 1'b1;
					end
				end
				S_WAIT_IDLE: begin
					if (chip_filtered == C0) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample_now) begin
			chip_q <= chip_filtered;
		end
	end

	assign chip_sample = '{strobe: strobe, chip: chip_q};

endmodule

//--- verilog/dsi3_filter.sv
`timescale 1ns/1ps

module dsi3_filter #(
	parameter int unsigned FILTER_LONG  = 24,
	parameter int unsigned FILTER_SHORT = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [1:0]           rx,
	input  logic                 short_filter_time,
	output dsi3_pkg::dsi3_chip_e chip_filtered
);
	import dsi3_pkg::*;

	localparam int unsigned LIMIT_MAX =
		(FILTER_LONG > FILTER_SHORT) ? FILTER_LONG : FILTER_SHORT;
	localparam int unsigned CNT_W     = $clog2(LIMIT_MAX + 1);

	logic [1:0]       rx_meta;
	logic [1:0]       rx_sync;
	logic [CNT_W-1:0] limit;
	logic [CNT_W-1:0] count [2];
	logic [CNT_W-1:0] count_clamped [2];
	logic [CNT_W-1:0] count_next [2];
	logic [1:0]       level;
	dsi3_chip_e       chip_next;

	// ======================================================================
	// Input synchronizer
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 2'b00;
			rx_sync <= 2'b00;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// ======================================================================
	// One integrating counter per comparator
	// ======================================================================

	assign limit = short_filter_time ? CNT_W'(FILTER_SHORT) : CNT_W'(FILTER_LONG);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// Limit may drop under a running count when the filter time switches
			count_clamped[i] = (count[i] > limit) ? limit : count[i];
			if (rx_sync[i]) begin
				count_next[i] = (count_clamped[i] == limit) ? limit : count_clamped[i] + 1'b1;
			end else begin
				count_next[i] = (count_clamped[i] == '0) ? '0 : count_clamped[i] - 1'b1;
			end
		end
	end

	// Output bit flips only at the two ends of the range
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				count[i] <= '0;
			end
			level <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				count[i] <= count_next[i];
				if (count_next[i] == limit) begin
					level[i] <= 1'b1;
				end else if (count_next[i] == '0) begin
					level[i] <= 1'b0;
				end
			end
		end
	end

	// Rebuild the chip and map the upper bit alone to C1
	always_comb begin
		case (level)
			2'b00:   chip_next = C0;
			2'b01:   chip_next = C1;
			2'b11:   chip_next = C2;
			default: chip_next = C1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chip_filtered <= C0;
		end else begin
			chip_filtered <= chip_next;
		end
	end

endmodule

//--- verilog/dsi3_pkg.sv
package dsi3_pkg;

	// ======================================================================
	// Sizes and chip coding
	// ======================================================================

	localparam int unsigned PACKET_SYMBOLS_MAX = 8;

	// Thermometer code of the two comparators with bit 0 as the low threshold
	typedef enum logic [1:0] {
		C0 = 2'b00,
		C1 = 2'b01,
		C2 = 2'b11
	} dsi3_chip_e;

	typedef struct packed {
		logic       strobe;
		dsi3_chip_e chip;
	} chip_sample_s;

	// First symbol in the top nibble and unused low nibbles kept at zero
	typedef struct packed {
		logic                            valid;
		logic [4*PACKET_SYMBOLS_MAX-1:0] data;
		logic                            error;
	} dsi3_packet_s;

	typedef struct packed {
		dsi3_chip_e first;
		dsi3_chip_e second;
		dsi3_chip_e third;
	} chip_triplet_s;

	typedef struct packed {
		logic       found;
		logic [3:0] symbol;
	} symbol_lookup_s;

	// ======================================================================
	// Symbol table of 16 out of the 27 possible triplets
	// ======================================================================

	// Entry n holds the chip sequence of symbol n
	localparam chip_triplet_s symbol_chip_table [16] = '{
		'{C1, C0, C1}, '{C1, C0, C2}, '{C1, C2, C0}, '{C1, C2, C1},
		'{C2, C0, C1}, '{C2, C0, C2}, '{C2, C1, C0}, '{C2, C1, C2},
		'{C0, C1, C0}, '{C0, C1, C2}, '{C0, C2, C0}, '{C0, C2, C1},
		'{C1, C1, C0}, '{C1, C1, C2}, '{C2, C2, C0}, '{C2, C2, C1}
	};

	function automatic symbol_lookup_s chips_to_symbol(input chip_triplet_s triplet);
		symbol_lookup_s result;
		result = '{found: 1'b0, symbol: 4'h0};
		for (int i = 0; i < 16; i++) begin
			if (symbol_chip_table[i] == triplet) begin
				result.found  = 1'b1;
				result.symbol = 4'(i);
			end
		end
		return result;
	endfunction

endpackage
